//--- logic/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    localparam logic [XLEN-1:0] LED_ADDR    = 32'hFFFF_FF00;
    localparam logic [XLEN-1:0] SWITCH_ADDR = 32'hFFFF_FF04;

    // Writeback source select
    localparam logic [1:0] WB_ALU = 2'd0;
    localparam logic [1:0] WB_MEM = 2'd1;
    localparam logic [1:0] WB_PC4 = 2'd2;

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } alu_op_e;

    typedef struct packed {
        logic [6:0]            funct7;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]           imm;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]            imm_hi;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [4:0]            imm_lo;
        logic [6:0]            opcode;
    } s_fmt_t;

    typedef struct packed {
        logic                  imm_12;
        logic [5:0]            imm_10_5;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [3:0]            imm_4_1;
        logic                  imm_11;
        logic [6:0]            opcode;
    } b_fmt_t;

    typedef struct packed {
        logic                  imm_20;
        logic [9:0]            imm_10_1;
        logic                  imm_11;
        logic [7:0]            imm_19_12;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        j_fmt_t j_fmt;
    } inst_u;

    typedef struct packed {
        alu_op_e    alu_op;
        logic       alu_src_imm;
        logic       mem_read;
        logic       mem_write;
        logic       reg_write;
        logic [1:0] wb_sel;
        logic       branch;
        logic       branch_ne;
        logic       jump;
    } ctrl_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        inst_u           inst;
    } if_id_t;

    typedef struct packed {
        ctrl_t                 ctrl;
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       rs1_data;
        logic [XLEN-1:0]       rs2_data;
        logic [XLEN-1:0]       imm;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
    } id_ex_t;

    typedef struct packed {
        ctrl_t                 ctrl;
        logic [XLEN-1:0]       alu_res;
        logic [XLEN-1:0]       store_data;
        logic [XLEN-1:0]       pc_4;
        logic [REG_ADDR_W-1:0] rd;
    } ex_mem_t;

    typedef struct packed {
        logic                  reg_write;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       wb_data;
    } mem_wb_t;

endpackage

`default_nettype wire

//--- logic/fetch_stage.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_stage (
    input  logic                      cpuclk,
    input  logic                      arst_n,
    input  logic                      run,
    input  logic                      stall,
    input  logic                      redirect,
    input  logic [cpu_pkg::XLEN-1:0]  redirect_pc,
    input  logic [cpu_pkg::XLEN-1:0]  imem_rdata,
    output logic [cpu_pkg::XLEN-1:0]  imem_addr,
    output cpu_pkg::if_id_t           if_id
);

    logic [cpu_pkg::XLEN-1:0] pc;

    assign imem_addr = pc;

    always_ff @(posedge cpuclk or negedge arst_n) begin
        if (!arst_n) begin
            pc    <= '0;
            if_id <= '0;
        end else if (run) begin                         // Held at 0 while the loader runs
            if (redirect) begin
                pc    <= redirect_pc;
                if_id <= '0;                            // Drop the wrong-path fetch
            end else if (!stall) begin
                pc         <= pc + 32'd4;
                if_id.pc   <= pc;
                if_id.inst <= imem_rdata;
            end
        end
    end

    pc_aligned_a: assert property (@(posedge cpuclk) disable iff (!arst_n)
        pc[1:0] == 2'b00);

endmodule

`default_nettype wire

//--- logic/decode_stage.sv
`timescale 1ns/1ns
`default_nettype none

module decode_stage (
    input  logic             cpuclk,
    input  logic             arst_n,
    input  cpu_pkg::if_id_t  if_id,
    input  logic             redirect,
    input  cpu_pkg::mem_wb_t mem_wb,
    output logic             stall,
    output cpu_pkg::id_ex_t  id_ex
);

    cpu_pkg::inst_u           inst;
    cpu_pkg::ctrl_t           ctrl;
    logic [cpu_pkg::XLEN-1:0] imm;
    logic [cpu_pkg::XLEN-1:0] rs1_data;
    logic [cpu_pkg::XLEN-1:0] rs2_data;
    logic [cpu_pkg::XLEN-1:0] regs [32];
    logic                     uses_rs1;
    logic                     uses_rs2;

    assign inst = if_id.inst;

    function automatic cpu_pkg::alu_op_e funct_to_alu(input logic [2:0] funct3,
                                                      input logic       sub);
        case (funct3)
            3'b000:  return sub ? cpu_pkg::ALU_SUB : cpu_pkg::ALU_ADD;
            3'b010:  return cpu_pkg::ALU_SLT;
            3'b100:  return cpu_pkg::ALU_XOR;
            3'b110:  return cpu_pkg::ALU_OR;
            3'b111:  return cpu_pkg::ALU_AND;
            default: return cpu_pkg::ALU_ADD;
        endcase
    endfunction

    always_comb begin
        ctrl = '0;
        imm  = '0;
        case (inst.r_fmt.opcode)
            cpu_pkg::OPC_OP: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = funct_to_alu(inst.r_fmt.funct3, inst.r_fmt.funct7[5]);
            end
            cpu_pkg::OPC_OP_IMM: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.alu_op      = funct_to_alu(inst.i_fmt.funct3, 1'b0);
                imm              = {{20{inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
            end
            cpu_pkg::OPC_LOAD: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.mem_read    = 1'b1;
                ctrl.wb_sel      = cpu_pkg::WB_MEM;
                imm              = {{20{inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
            end
            cpu_pkg::OPC_STORE: begin
                ctrl.alu_src_imm = 1'b1;
                ctrl.mem_write   = 1'b1;
                imm = {{20{inst.s_fmt.imm_hi[6]}}, inst.s_fmt.imm_hi, inst.s_fmt.imm_lo};
            end
            cpu_pkg::OPC_BRANCH: begin
                ctrl.branch    = 1'b1;
                ctrl.branch_ne = inst.b_fmt.funct3[0];  // bne has funct3 001
                imm = {{19{inst.b_fmt.imm_12}}, inst.b_fmt.imm_12, inst.b_fmt.imm_11,
                       inst.b_fmt.imm_10_5, inst.b_fmt.imm_4_1, 1'b0};
            end
            cpu_pkg::OPC_JAL: begin
                ctrl.jump      = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = cpu_pkg::WB_PC4;
                imm = {{11{inst.j_fmt.imm_20}}, inst.j_fmt.imm_20, inst.j_fmt.imm_19_12,
                       inst.j_fmt.imm_11, inst.j_fmt.imm_10_1, 1'b0};
            end
            default: ;
        endcase
    end

    // Writeback in the same cycle is bypassed into the read data
    always_comb begin
        rs1_data = regs[inst.r_fmt.rs1];
        rs2_data = regs[inst.r_fmt.rs2];
        if (mem_wb.reg_write && mem_wb.rd == inst.r_fmt.rs1)
            rs1_data = mem_wb.wb_data;
        if (mem_wb.reg_write && mem_wb.rd == inst.r_fmt.rs2)
            rs2_data = mem_wb.wb_data;
        if (inst.r_fmt.rs1 == '0)
            rs1_data = '0;
        if (inst.r_fmt.rs2 == '0)
            rs2_data = '0;
    end

    always_ff @(posedge cpuclk) begin
        if (mem_wb.reg_write && mem_wb.rd != '0)
            regs[mem_wb.rd] <= mem_wb.wb_data;
    end

    assign uses_rs1 = inst.r_fmt.opcode != cpu_pkg::OPC_JAL;
    assign uses_rs2 = inst.r_fmt.opcode == cpu_pkg::OPC_OP ||
                      inst.r_fmt.opcode == cpu_pkg::OPC_STORE ||
                      inst.r_fmt.opcode == cpu_pkg::OPC_BRANCH;

    assign stall = id_ex.ctrl.mem_read && id_ex.rd != '0 &&
                   ((uses_rs1 && id_ex.rd == inst.r_fmt.rs1) ||
                    (uses_rs2 && id_ex.rd == inst.r_fmt.rs2));

    always_ff @(posedge cpuclk or negedge arst_n) begin
        if (!arst_n) begin
            id_ex <= '0;
        end else if (redirect || stall) begin
            id_ex <= '0;                                // Bubble
        end else begin
            id_ex.ctrl     <= ctrl;
            id_ex.pc       <= if_id.pc;
            id_ex.rs1_data <= rs1_data;
            id_ex.rs2_data <= rs2_data;
            id_ex.imm      <= imm;
            id_ex.rs1      <= inst.r_fmt.rs1;
            id_ex.rs2      <= inst.r_fmt.rs2;
            id_ex.rd       <= inst.r_fmt.rd;
        end
    end

    // A load in EX never redirects, so both bubbles never hit one entry
    no_stall_on_redirect_a: assert property (@(posedge cpuclk) disable iff (!arst_n)
        !(stall && redirect));

endmodule

`default_nettype wire

//--- logic/execute_stage.sv
`timescale 1ns/1ns
`default_nettype none

module execute_stage (
    input  logic                     cpuclk,
    input  logic                     arst_n,
    input  cpu_pkg::id_ex_t          id_ex,
    input  cpu_pkg::mem_wb_t         mem_wb,
    output cpu_pkg::ex_mem_t         ex_mem,
    output logic                     redirect,
    output logic [cpu_pkg::XLEN-1:0] redirect_pc
);

    logic [cpu_pkg::XLEN-1:0] op_a;
    logic [cpu_pkg::XLEN-1:0] rs2_val;
    logic [cpu_pkg::XLEN-1:0] op_b;
    logic [cpu_pkg::XLEN-1:0] alu_res;
    logic                     taken;

    function automatic logic [cpu_pkg::XLEN-1:0] forward(
        input logic [cpu_pkg::REG_ADDR_W-1:0] rs,
        input logic [cpu_pkg::XLEN-1:0]       reg_val,
        input cpu_pkg::ex_mem_t               em,
        input cpu_pkg::mem_wb_t               mw
    );
        if (rs == '0)
            return reg_val;
        if (em.ctrl.reg_write && em.rd == rs)
            return em.alu_res;                          // Younger result wins
        if (mw.reg_write && mw.rd == rs)
            return mw.wb_data;
        return reg_val;
    endfunction

    assign op_a    = forward(id_ex.rs1, id_ex.rs1_data, ex_mem, mem_wb);
    assign rs2_val = forward(id_ex.rs2, id_ex.rs2_data, ex_mem, mem_wb);
    assign op_b    = id_ex.ctrl.alu_src_imm ? id_ex.imm : rs2_val;

    always_comb begin
        case (id_ex.ctrl.alu_op)
            cpu_pkg::ALU_ADD: alu_res = op_a + op_b;
            cpu_pkg::ALU_SUB: alu_res = op_a - op_b;
            cpu_pkg::ALU_AND: alu_res = op_a & op_b;
            cpu_pkg::ALU_OR:  alu_res = op_a | op_b;
            cpu_pkg::ALU_XOR: alu_res = op_a ^ op_b;
            cpu_pkg::ALU_SLT: alu_res = {{(cpu_pkg::XLEN-1){1'b0}},
                                         $signed(op_a) < $signed(op_b)};
            default:          alu_res = op_a + op_b;
        endcase
    end

    assign taken       = id_ex.ctrl.branch && ((op_a == rs2_val) ^ id_ex.ctrl.branch_ne);
    assign redirect    = taken || id_ex.ctrl.jump;
    assign redirect_pc = id_ex.pc + id_ex.imm;

    always_ff @(posedge cpuclk or negedge arst_n) begin
        if (!arst_n) begin
            ex_mem <= '0;
        end else begin
            ex_mem.ctrl       <= id_ex.ctrl;
            ex_mem.alu_res    <= alu_res;
            ex_mem.store_data <= rs2_val;
            ex_mem.pc_4       <= id_ex.pc + 32'd4;
            ex_mem.rd         <= id_ex.rd;
        end
    end

endmodule

`default_nettype wire

//--- logic/access_stage.sv
`timescale 1ns/1ns
`default_nettype none

module access_stage (
    input  logic                     cpuclk,
    input  logic                     arst_n,
    input  cpu_pkg::ex_mem_t         ex_mem,
    input  logic [cpu_pkg::XLEN-1:0] dmem_rdata,
    output logic [cpu_pkg::XLEN-1:0] dmem_addr,
    output logic [cpu_pkg::XLEN-1:0] dmem_wdata,
    output logic                     dmem_we,
    output cpu_pkg::mem_wb_t         mem_wb
);

    logic [cpu_pkg::XLEN-1:0] wb_data;

    assign dmem_addr  = ex_mem.alu_res;
    assign dmem_wdata = ex_mem.store_data;
    assign dmem_we    = ex_mem.ctrl.mem_write;

    always_comb begin
        case (ex_mem.ctrl.wb_sel)
            cpu_pkg::WB_MEM: wb_data = dmem_rdata;      // Read is combinational
            cpu_pkg::WB_PC4: wb_data = ex_mem.pc_4;
            default:         wb_data = ex_mem.alu_res;
        endcase
    end

    always_ff @(posedge cpuclk or negedge arst_n) begin
        if (!arst_n) begin
            mem_wb <= '0;
        end else begin
            mem_wb.reg_write <= ex_mem.ctrl.reg_write;
            mem_wb.rd        <= ex_mem.rd;
            mem_wb.wb_data   <= wb_data;
        end
    end

endmodule

`default_nettype wire

//--- logic/unified_memory.sv
`timescale 1ns/1ns
`default_nettype none

module unified_memory #(
    parameter int MEM_WORDS = 1024
) (
    input  logic                     cpuclk,
    input  logic                     arst_n,
    input  logic [cpu_pkg::XLEN-1:0] imem_addr,
    input  logic [cpu_pkg::XLEN-1:0] dmem_addr,
    input  logic [cpu_pkg::XLEN-1:0] dmem_wdata,
    input  logic                     dmem_we,
    input  logic [cpu_pkg::XLEN-1:0] uart_data,
    input  logic [cpu_pkg::XLEN-1:0] uart_addr,
    input  logic                     uart_finish,
    input  logic [7:0]               switches,
    output logic [cpu_pkg::XLEN-1:0] imem_rdata,
    output logic [cpu_pkg::XLEN-1:0] dmem_rdata,
    output logic [cpu_pkg::XLEN-1:0] led_out
);

    localparam int IDX_W = $clog2(MEM_WORDS);

    logic [cpu_pkg::XLEN-1:0] ram [MEM_WORDS];
    logic [IDX_W-1:0]         imem_idx;
    logic [IDX_W-1:0]         dmem_idx;
    logic [IDX_W-1:0]         wr_idx;
    logic [cpu_pkg::XLEN-1:0] wr_data;
    logic                     is_led;
    logic                     is_switch;
    logic                     ram_we;

    assign imem_idx  = imem_addr[IDX_W+1:2];
    assign dmem_idx  = dmem_addr[IDX_W+1:2];
    assign is_led    = dmem_addr == cpu_pkg::LED_ADDR;
    assign is_switch = dmem_addr == cpu_pkg::SWITCH_ADDR;

    // Loader owns the write port until it finishes, uart_addr is a word index
    assign wr_idx  = uart_finish ? dmem_idx : uart_addr[IDX_W-1:0];
    assign wr_data = uart_finish ? dmem_wdata : uart_data;
    assign ram_we  = uart_finish ? (dmem_we && !is_led && !is_switch) : 1'b1;

    always_ff @(posedge cpuclk) begin
        if (ram_we)
            ram[wr_idx] <= wr_data;
    end

    always_ff @(posedge cpuclk or negedge arst_n) begin
        if (!arst_n)
            led_out <= '0;
        else if (uart_finish && dmem_we && is_led)
            led_out <= dmem_wdata;
    end

    assign imem_rdata = ram[imem_idx];
    assign dmem_rdata = is_switch ? {24'b0, switches} : ram[dmem_idx];

    ram_range_a: assert property (@(posedge cpuclk) disable iff (!arst_n)
        (uart_finish ? (!ram_we || dmem_addr[cpu_pkg::XLEN-1:2] < MEM_WORDS) &&
                       imem_addr[cpu_pkg::XLEN-1:2] < MEM_WORDS
                     : uart_addr < MEM_WORDS));

endmodule

`default_nettype wire

//--- logic/cpu_top.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_top #(
    parameter int MEM_WORDS = 1024
) (
    input  logic                     cpuclk,
    input  logic                     arst_n,
    input  logic [7:0]               switches,
    input  logic [cpu_pkg::XLEN-1:0] uart_data,
    input  logic [cpu_pkg::XLEN-1:0] uart_addr,
    input  logic                     uart_finish,
    output logic [cpu_pkg::XLEN-1:0] led_out
);

    logic                     stall;
    logic                     redirect;
    logic [cpu_pkg::XLEN-1:0] redirect_pc;
    logic [cpu_pkg::XLEN-1:0] imem_addr;
    logic [cpu_pkg::XLEN-1:0] imem_rdata;
    logic [cpu_pkg::XLEN-1:0] dmem_addr;
    logic [cpu_pkg::XLEN-1:0] dmem_wdata;
    logic [cpu_pkg::XLEN-1:0] dmem_rdata;
    logic                     dmem_we;
    cpu_pkg::if_id_t          if_id;
    cpu_pkg::id_ex_t          id_ex;
    cpu_pkg::ex_mem_t         ex_mem;
    cpu_pkg::mem_wb_t         mem_wb;

    fetch_stage fetch_stage_i (
        .cpuclk, .arst_n,
        .run(uart_finish),
        .stall, .redirect, .redirect_pc,
        .imem_rdata, .imem_addr,
        .if_id
    );

    decode_stage decode_stage_i (
        .cpuclk, .arst_n,
        .if_id, .redirect, .mem_wb,
        .stall, .id_ex
    );

    execute_stage execute_stage_i (
        .cpuclk, .arst_n,
        .id_ex, .mem_wb,
        .ex_mem, .redirect, .redirect_pc
    );

    access_stage access_stage_i (
        .cpuclk, .arst_n,
        .ex_mem, .dmem_rdata,
        .dmem_addr, .dmem_wdata, .dmem_we,
        .mem_wb
    );

    unified_memory #(.MEM_WORDS(MEM_WORDS)) unified_memory_i (
        .cpuclk, .arst_n,
        .imem_addr, .dmem_addr, .dmem_wdata, .dmem_we,
        .uart_data, .uart_addr, .uart_finish, .switches,
        .imem_rdata, .dmem_rdata, .led_out
    );

endmodule

`default_nettype wire

//--- testbench/cpu_tb_programs.svh
`default_nettype none

// Encoders follow the RV32I field order, arguments left to right
function automatic logic [31:0] r_type(input int f7, input int rs2, input int rs1,
                                       input int f3, input int rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
endfunction

function automatic logic [31:0] i_type(input int imm, input int rs1, input int f3,
                                       input int rd, input logic [6:0] opc);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
endfunction

function automatic logic [31:0] s_type(input int imm, input int rs2, input int rs1);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
endfunction

function automatic logic [31:0] b_type(input int imm, input int rs2, input int rs1,
                                       input int f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
            7'b1100011};
endfunction

function automatic logic [31:0] j_type(input int imm, input int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
endfunction

function automatic logic [31:0] add_imm(input int rd, input int rs1, input int imm);
    return i_type(imm, rs1, 0, rd, 7'b0010011);
endfunction

function automatic logic [31:0] load_word(input int rd, input int rs1, input int imm);
    return i_type(imm, rs1, 2, rd, 7'b0000011);
endfunction

function automatic logic [31:0] led_store(input int rs2);
    return s_type(0, rs2, 1);                       // x1 holds the LED address
endfunction

function automatic int sext12(input int v);
    return {{20{v[11]}}, v[11:0]};
endfunction

task automatic emit(input logic [31:0] word);
    prog[prog_len] = word;
    prog_len++;
endtask

task automatic expect_led(input logic [31:0] value);
    raw[raw_len] = value;
    raw_len++;
endtask

task automatic build_test(input int num);
    int a;
    int b;
    int c;
    int link1;
    int link2;
    prog_len = 0;
    raw_len  = 0;
    a = sext12($urandom_range(4095));
    b = sext12($urandom_range(4095));
    c = sext12($urandom_range(4095));
    emit(add_imm(1, 0, -256));                      // 32'hFFFF_FF00 is the LED word
    case (num)
        1: begin
            emit(add_imm(2, 0, a));
            emit(add_imm(3, 0, b));
            emit(led_store(2));
            emit(r_type(0, 3, 2, 0, 4));            // add
            emit(led_store(4));
            emit(r_type(32, 3, 2, 0, 5));           // sub
            emit(led_store(5));
            emit(r_type(0, 3, 2, 7, 6));            // and
            emit(led_store(6));
            emit(r_type(0, 3, 2, 6, 7));            // or
            emit(led_store(7));
            emit(r_type(0, 3, 2, 4, 8));            // xor
            emit(led_store(8));
            emit(r_type(0, 3, 2, 2, 9));            // slt
            emit(led_store(9));
            emit(add_imm(10, 2, c));
            emit(led_store(10));
            expect_led(a);
            expect_led(a + b);
            expect_led(a - b);
            expect_led(a & b);
            expect_led(a | b);
            expect_led(a ^ b);
            expect_led((a < b) ? 1 : 0);
            expect_led(a + c);
        end
        2: begin
            emit(add_imm(2, 0, a));
            emit(add_imm(3, 2, b));                 // Takes x2 from EX/MEM
            emit(r_type(0, 2, 3, 0, 4));            // Takes x3 from EX/MEM and x2 from MEM/WB
            emit(r_type(0, 3, 4, 7, 5));
            emit(led_store(5));
            emit(r_type(0, 4, 5, 4, 6));
            emit(add_imm(0, 0, 0));
            emit(led_store(6));                     // Store data comes from MEM/WB
            expect_led((2 * a + b) & (a + b));
            expect_led(((2 * a + b) & (a + b)) ^ (2 * a + b));
        end
        3: begin
            emit(add_imm(2, 0, a));
            emit(add_imm(3, 0, b));
            emit(s_type(512, 2, 0));
            emit(load_word(4, 0, 512));
            emit(r_type(0, 3, 4, 0, 5));            // Needs the loaded x4 at once
            emit(led_store(5));
            emit(load_word(6, 0, 512));
            emit(led_store(6));
            expect_led(a + b);
            expect_led(a);
        end
        4: begin
            a = $urandom_range(1000) + 1;
            emit(add_imm(2, 0, a));
            emit(add_imm(3, 0, a));
            emit(add_imm(4, 2, 2));
            emit(b_type(8, 3, 2, 1));               // bne over the first store, not taken
            emit(led_store(2));
            emit(b_type(12, 3, 2, 0));              // beq past both shadow stores
            emit(led_store(4));
            emit(led_store(0));
            emit(add_imm(5, 2, 1));
            emit(led_store(5));
            expect_led(a);
            expect_led(a + 1);
        end
        5: begin
            link1 = 4 * prog_len + 4;
            emit(j_type(12, 5));
            emit(led_store(0));
            emit(led_store(1));
            emit(led_store(5));
            link2 = 4 * prog_len + 4;
            emit(j_type(8, 6));
            emit(led_store(1));
            emit(r_type(0, 5, 6, 0, 7));
            emit(led_store(7));
            expect_led(link1);
            expect_led(link1 + link2);
        end
        default: begin
            switches = 8'($urandom_range(254) + 1);
            emit(add_imm(2, 0, -252));              // Switch word sits right above the LEDs
            emit(load_word(3, 2, 0));
            emit(led_store(3));
            expect_led({24'b0, switches});
        end
    endcase
    emit(j_type(0, 0));                             // Spin in place at the end
endtask

`default_nettype wire

//--- testbench/cpu_tb.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_tb;

    localparam int NUM_TESTS       = 6;
    localparam int CYCLES_PER_TEST = 300;
    localparam int CYCLE_LIMIT     = NUM_TESTS * CYCLES_PER_TEST;

    logic                     cpuclk;
    logic                     arst_n;
    logic [7:0]               switches;
    logic [cpu_pkg::XLEN-1:0] uart_data;
    logic [cpu_pkg::XLEN-1:0] uart_addr;
    logic                     uart_finish;
    logic [cpu_pkg::XLEN-1:0] led_out;

    logic [31:0] prog [64];
    int          prog_len;
    logic [31:0] raw [16];
    int          raw_len;
    logic [31:0] exp_led [16];
    int          exp_len;
    logic [31:0] exp_now;
    logic [31:0] led_prev;
    int          chk_idx;
    int          cycles;
    int          errors;
    int          checks;
    string       test_names [NUM_TESTS] = '{"alu", "forwarding", "load-use",
                                            "branch", "jal", "switches"};

    cpu_top #(.MEM_WORDS(1024)) cpu_top_i (
        .cpuclk, .arst_n, .switches,
        .uart_data, .uart_addr, .uart_finish,
        .led_out
    );

    always #5 cpuclk = ~cpuclk;

    // Counts the LED changes already checked in the running test
    always @(posedge cpuclk) begin
        if (!arst_n) begin
            chk_idx  <= 0;
            led_prev <= '0;
        end else begin
            if (led_out != led_prev)
                chk_idx <= chk_idx + 1;
            led_prev <= led_out;
        end
    end

    assign exp_now = (chk_idx < exp_len) ? exp_led[chk_idx] : '0;

    led_sequence_a: assert property (@(posedge cpuclk) disable iff (!arst_n)
        $changed(led_out) |-> chk_idx < exp_len && led_out == exp_now)
        else begin
            errors++;
            $display("FAIL at %0t ns: led_out is %h, expected %h",
                     $time, $sampled(led_out), $sampled(exp_now));
        end

    always @(posedge cpuclk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the LED sequence never completed", CYCLE_LIMIT);
            $display("Something failed");
            $finish;
        end
    end

    // LEDs only show a change, so a repeated value is never seen
    task automatic keep_distinct();
        logic [31:0] last;
        last    = '0;
        exp_len = 0;
        for (int i = 0; i < raw_len; i++) begin
            if (raw[i] != last) begin
                exp_led[exp_len] = raw[i];
                exp_len++;
            end
            last = raw[i];
        end
    endtask

    task automatic run_test(input int num);
        int errs_before;
        errs_before = errors;
        build_test(num);
        keep_distinct();
        uart_finish = 1'b0;
        arst_n      = 1'b0;
        repeat (3) @(negedge cpuclk);
        arst_n = 1'b1;
        for (int i = 0; i < prog_len; i++) begin
            uart_addr = i;                              // Word index
            uart_data = prog[i];
            @(negedge cpuclk);
        end
        uart_finish = 1'b1;
        while (chk_idx < exp_len)
            @(negedge cpuclk);
        checks += exp_len;
        $display("Test %0d (%s): %0d LED values, %0d errors",
                 num, test_names[num-1], exp_len, errors - errs_before);
    endtask

    initial begin
        void'($urandom(32'ha609762f));
        cpuclk      = 1'b0;
        arst_n      = 1'b0;
        switches    = '0;
        uart_data   = '0;
        uart_addr   = '0;
        uart_finish = 1'b0;
        cycles      = 0;
        errors      = 0;
        checks      = 0;
        @(negedge cpuclk);
        for (int t = 1; t <= NUM_TESTS; t++)
            run_test(t);
        $display("Tests: %0d, LED checks: %0d, errors: %0d", NUM_TESTS, checks, errors);
        if (errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

    `include "cpu_tb_programs.svh"

endmodule

`default_nettype wire

//--- riscv_pipe.f
+incdir+testbench
logic/cpu_pkg.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/access_stage.sv
logic/unified_memory.sv
logic/cpu_top.sv
testbench/cpu_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log for the pass line
cd "$(dirname "$0")" \
    && rm -f sim.log \
    && verilator --binary --timing --assert -Wno-fatal --top-module cpu_tb \
        -f riscv_pipe.f -o cpu_tb_sim \
    && { ./obj_dir/cpu_tb_sim | tee sim.log; } \
    && grep -qx "Everything OK" sim.log \
    || { echo "Simulation did not pass, see sim.log"; exit 1; }
